//--- verilog/spart_pkg.sv
`default_nettype none

package spart_pkg;

	////////////////////
	// Data widths
	////////////////////

	// One APB data word
	typedef logic [31:0] word_t;
	// One serial character
	typedef logic [7:0] byte_t;
	// Clock cycles per serial bit
	typedef logic [15:0] divisor_t;
	// APB byte address of a register
	typedef logic [3:0] reg_addr_t;

	localparam int BYTES_PER_WORD = 4;

	// Position of a byte inside a word
	typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_idx_t;

	////////////////////
	// Register map
	////////////////////

	localparam reg_addr_t ADDR_DATA    = 4'd0;
	localparam reg_addr_t ADDR_STATUS  = 4'd4;
	localparam reg_addr_t ADDR_DIVISOR = 4'd8;

	// 115200 baud at 100 MHz
	localparam divisor_t DIVISOR_RESET = 16'd868;

	// Bit positions in the STATUS read value
	localparam int STATUS_TX_BUSY  = 0;
	localparam int STATUS_RX_READY = 1;
	localparam int STATUS_OVERRUN  = 2;

	////////////////////
	// FSM states
	////////////////////

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

`default_nettype wire

//--- verilog/spart_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Word level link between the APB slave and the word engine
interface spart_word_if import spart_pkg::*; ();
	// Transmit word handshake
	word_t    tx_word;
	logic     tx_valid;
	logic     tx_ready;
	// Receive word and its flags
	word_t    rx_word;
	logic     rx_ready;
	logic     overrun;
	// One cycle pulse, clears rx_ready and overrun
	logic     rx_take;
	// Bit period from the DIVISOR register
	divisor_t divisor;

	modport host (
		output tx_word, tx_valid, rx_take, divisor,
		input  tx_ready, rx_word, rx_ready, overrun
	);

	modport engine (
		input  tx_word, tx_valid, rx_take, divisor,
		output tx_ready, rx_word, rx_ready, overrun
	);
endinterface

// Byte level link between the word engine and the serial shifters
interface spart_byte_if import spart_pkg::*; ();
	byte_t    tx_byte;
	logic     tx_start;
	logic     tx_busy;
	byte_t    rx_byte;
	logic     rx_strobe;
	divisor_t divisor;

	modport engine (
		output tx_byte, tx_start, divisor,
		input  tx_busy, rx_byte, rx_strobe
	);

	modport uart (
		input  tx_byte, tx_start, divisor,
		output tx_busy, rx_byte, rx_strobe
	);
endinterface

`default_nettype wire

//--- verilog/spart_apb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spart_apb_slave
	import spart_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_psel,
	input  logic       i_penable,
	input  logic       i_pwrite,
	input  reg_addr_t  i_paddr,
	input  word_t      i_pwdata,
	output word_t      o_prdata,
	output logic       o_pready,
	output logic       o_pslverr,
	spart_word_if.host word
);

	logic  access;
	logic  sel_data;
	logic  sel_status;
	logic  sel_divisor;
	logic  sel_none;
	logic  data_wr;
	logic  data_rd;
	word_t status_word;

	////////////////////
	// Address decode
	////////////////////

	// Access phase of an APB transfer
	assign access      = i_psel & i_penable;
	assign sel_data    = (i_paddr == ADDR_DATA);
	assign sel_status  = (i_paddr == ADDR_STATUS);
	assign sel_divisor = (i_paddr == ADDR_DIVISOR);
	assign sel_none    = ~(sel_data | sel_status | sel_divisor);

	assign data_wr = access & i_pwrite & sel_data;
	assign data_rd = access & ~i_pwrite & sel_data;

	// Word offered to the engine for the whole DATA write
	assign word.tx_word  = i_pwdata;
	assign word.tx_valid = data_wr;
	// Pop only when a word is actually there
	assign word.rx_take  = data_rd & word.rx_ready;

	////////////////////
	// Response
	////////////////////

	// DATA write stalls until the engine takes the word, all else is zero wait
	assign o_pready  = access & (~data_wr | word.tx_ready);
	// Unmapped address or a DATA read with nothing received
	assign o_pslverr = access & (sel_none | (data_rd & ~word.rx_ready));

	// Busy means a word still waits in the engine
	always_comb
	begin
		status_word = '0;
		status_word[STATUS_TX_BUSY]  = ~word.tx_ready;
		status_word[STATUS_RX_READY] = word.rx_ready;
		status_word[STATUS_OVERRUN]  = word.overrun;
	end

	// Read data mux, zero outside reads
	always_comb
	begin
		o_prdata = '0;
		if (access && !i_pwrite)
		begin
			if (sel_data && word.rx_ready)
				o_prdata = word.rx_word;
			else if (sel_status)
				o_prdata = status_word;
			else if (sel_divisor)
				o_prdata = word_t'(word.divisor);
		end
	end

	// DIVISOR register
	always_ff @(posedge clk)
	begin
		if (rst)
			word.divisor <= DIVISOR_RESET;
		else if (access && i_pwrite && sel_divisor)
			word.divisor <= i_pwdata[$bits(divisor_t)-1:0];
	end

endmodule

`default_nettype wire

//--- verilog/spart_word_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spart_word_engine
	import spart_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	spart_word_if.engine word,
	spart_byte_if.engine bytes
);

	word_t     tx_shift;
	logic      tx_pending;
	logic      tx_accept;
	byte_idx_t tx_idx;
	word_t     rx_asm;
	word_t     rx_next;
	byte_idx_t rx_idx;
	logic      rx_done;
	logic      rx_publish;

	// Bit period goes straight on to the shifters
	assign bytes.divisor = word.divisor;

	////////////////////
	// Transmit side
	////////////////////

	// Free again once the last byte of a word has started
	assign word.tx_ready = ~tx_pending;
	assign tx_accept     = word.tx_valid & ~tx_pending;

	// uart raises busy the cycle after, so this stays a single pulse
	assign bytes.tx_start = tx_pending & ~bytes.tx_busy;
	// LSB first, low byte always at the bottom
	assign bytes.tx_byte  = tx_shift[$bits(byte_t)-1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tx_pending <= 1'b0;
			tx_idx     <= '0;
		end
		else if (tx_accept)
		begin
			tx_pending <= 1'b1;
			tx_idx     <= '0;
		end
		else if (bytes.tx_start)
		begin
			tx_idx <= tx_idx + 1'b1;
			// Last byte launched
			if (tx_idx == byte_idx_t'(BYTES_PER_WORD - 1))
				tx_pending <= 1'b0;
		end
	end

	// Word buffer, shifts down one byte per start
	always_ff @(posedge clk)
	begin
		if (tx_accept)
			tx_shift <= word.tx_word;
		else if (bytes.tx_start)
			tx_shift <= tx_shift >> $bits(byte_t);
	end

	////////////////////
	// Receive side
	////////////////////

	// New byte enters at the top, first byte ends up lowest
	assign rx_next    = {bytes.rx_byte, rx_asm[$bits(word_t)-1:$bits(byte_t)]};
	assign rx_done    = bytes.rx_strobe & (rx_idx == byte_idx_t'(BYTES_PER_WORD - 1));
	// A take in the same cycle frees the slot
	assign rx_publish = rx_done & (~word.rx_ready | word.rx_take);

	always_ff @(posedge clk)
	begin
		if (bytes.rx_strobe)
			rx_asm <= rx_next;
		if (rx_publish)
			word.rx_word <= rx_next;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rx_idx        <= '0;
			word.rx_ready <= 1'b0;
			word.overrun  <= 1'b0;
		end
		else
		begin
			if (bytes.rx_strobe)
				rx_idx <= rx_idx + 1'b1;
			if (word.rx_take)
			begin
				word.rx_ready <= 1'b0;
				word.overrun  <= 1'b0;
			end
			// Completion wins over a same cycle take
			if (rx_publish)
				word.rx_ready <= 1'b1;
			else if (rx_done)
				word.overrun <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/spart_uart.sv
`timescale 1ns/1ps
`default_nettype none

module spart_uart
	import spart_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	spart_byte_if.uart bytes,
	input  logic       i_rxd,
	output logic       o_txd
);

	tx_state_e tx_state;
	divisor_t  tx_cnt;
	logic [2:0] tx_bit;
	byte_t     tx_shift;
	logic      tx_tick;

	rx_state_e rx_state;
	divisor_t  rx_cnt;
	logic [2:0] rx_bit;
	byte_t     rx_shift;
	logic      rx_tick;
	logic      rxd_meta;
	logic      rxd_sync;
	logic      rxd_last;
	divisor_t  bit_reload;

	// Counters run from divisor-1 down to zero, one bit time
	assign bit_reload = bytes.divisor - 1'b1;
	assign tx_tick    = (tx_cnt == '0);
	assign rx_tick    = (rx_cnt == '0);

	////////////////////
	// 8N1 transmitter
	////////////////////

	assign bytes.tx_busy = (tx_state != TX_IDLE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tx_state <= TX_IDLE;
			tx_cnt   <= '0;
			tx_bit   <= '0;
			o_txd    <= 1'b1;
		end
		else
		begin
			if (!tx_tick)
				tx_cnt <= tx_cnt - 1'b1;
			case (tx_state)
				TX_IDLE:
				begin
					if (bytes.tx_start)
					begin
						// Start bit
						tx_state <= TX_START;
						tx_cnt   <= bit_reload;
						o_txd    <= 1'b0;
					end
				end
				TX_START:
				begin
					if (tx_tick)
					begin
						tx_state <= TX_DATA;
						tx_cnt   <= bit_reload;
						tx_bit   <= '0;
						o_txd    <= tx_shift[0];
					end
				end
				TX_DATA:
				begin
					if (tx_tick)
					begin
						tx_cnt <= bit_reload;
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == 3'd7)
						begin
							// Stop bit
							tx_state <= TX_STOP;
							o_txd    <= 1'b1;
						end
						else
							o_txd <= tx_shift[tx_bit + 1'b1];
					end
				end
				default:
				begin
					if (tx_tick)
						tx_state <= TX_IDLE;
				end
			endcase
		end
	end

	// Byte held for the whole frame
	always_ff @(posedge clk)
	begin
		if (bytes.tx_start && !bytes.tx_busy)
			tx_shift <= bytes.tx_byte;
	end

	////////////////////
	// 8N1 receiver
	////////////////////

	// Two flop synchronizer plus one for edge detect, line idles high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end
		else
		begin
			rxd_meta <= i_rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	// Shift register doubles as the byte output
	assign bytes.rx_byte = rx_shift;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rx_state        <= RX_IDLE;
			rx_cnt          <= '0;
			rx_bit          <= '0;
			bytes.rx_strobe <= 1'b0;
		end
		else
		begin
			bytes.rx_strobe <= 1'b0;
			if (!rx_tick)
				rx_cnt <= rx_cnt - 1'b1;
			case (rx_state)
				RX_IDLE:
				begin
					// Falling edge, wait half a bit to land mid start bit
					if (rxd_last && !rxd_sync)
					begin
						rx_state <= RX_START;
						rx_cnt   <= (bytes.divisor >> 1) - 1'b1;
					end
				end
				RX_START:
				begin
					if (rx_tick)
					begin
						// Glitch if the line is high again
						rx_state <= rxd_sync ? RX_IDLE : RX_DATA;
						rx_cnt   <= bit_reload;
						rx_bit   <= '0;
					end
				end
				RX_DATA:
				begin
					if (rx_tick)
					begin
						rx_cnt <= bit_reload;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default:
				begin
					if (rx_tick)
					begin
						// Bad stop bit drops the frame
						rx_state        <= RX_IDLE;
						bytes.rx_strobe <= rxd_sync;
					end
				end
			endcase
		end
	end

	// LSB arrives first, enters at the top
	always_ff @(posedge clk)
	begin
		if (rx_state == RX_DATA && rx_tick)
			rx_shift <= {rxd_sync, rx_shift[7:1]};
	end

endmodule

`default_nettype wire

//--- verilog/spart_top.sv
`timescale 1ns/1ps
`default_nettype none

module spart_top
	import spart_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	// APB slave port
	input  logic      i_psel,
	input  logic      i_penable,
	input  logic      i_pwrite,
	input  reg_addr_t i_paddr,
	input  word_t     i_pwdata,
	output word_t     o_prdata,
	output logic      o_pready,
	output logic      o_pslverr,
	// Serial line
	input  logic      i_rxd,
	output logic      o_txd
);

	spart_word_if word_link ();
	spart_byte_if byte_link ();

	// Register side
	spart_apb_slave spart_apb_slave_inst (
		.clk       (clk),
		.rst       (rst),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.word      (word_link.host)
	);

	// Word split and assembly
	spart_word_engine spart_word_engine_inst (
		.clk   (clk),
		.rst   (rst),
		.word  (word_link.engine),
		.bytes (byte_link.engine)
	);

	// Serial shifters
	spart_uart spart_uart_inst (
		.clk   (clk),
		.rst   (rst),
		.bytes (byte_link.uart),
		.i_rxd (i_rxd),
		.o_txd (o_txd)
	);

endmodule

`default_nettype wire

//--- test/spart_props.sv
`timescale 1ns/1ps
`default_nettype none

module spart_props (
	input wire logic clk,
	input wire logic rst,
	input wire logic i_psel,
	input wire logic i_penable,
	input wire logic i_pready,
	input wire logic i_pslverr,
	input wire logic i_txd
);

	// Ready only inside an access phase
	a_ready_in_access: assert property (@(posedge clk) disable iff (rst)
		!(i_psel && i_penable) |-> !i_pready)
		else $error("PREADY high outside an APB access phase");

	// Line idles high straight out of reset
	a_txd_idle: assert property (@(posedge clk) rst |=> i_txd)
		else $error("serial line not high after reset");

	// Error response never without ready
	a_err_with_ready: assert property (@(posedge clk) disable iff (rst)
		i_pslverr |-> i_pready)
		else $error("PSLVERR high without PREADY");

endmodule

bind spart_top spart_props spart_props_inst (
	.clk       (clk),
	.rst       (rst),
	.i_psel    (i_psel),
	.i_penable (i_penable),
	.i_pready  (o_pready),
	.i_pslverr (o_pslverr),
	.i_txd     (o_txd)
);

`default_nettype wire

//--- test/tb_spart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spart
	import spart_pkg::*;
();

	// Run length: words on the line, bit times per word, slowest divisor, clock period
	localparam int     N_WORDS     = 25;
	localparam int     MAX_DIV     = 16;
	localparam longint WATCHDOG_NS = longint'(N_WORDS) * 40 * MAX_DIV * 20 + 100000;
	localparam word_t  STATUS_MASK = word_t'((1 << STATUS_TX_BUSY) | (1 << STATUS_RX_READY) |
		(1 << STATUS_OVERRUN));

	// Kinds of result in the compare queue
	localparam int KIND_WORD   = 0;
	localparam int KIND_STATUS = 1;
	localparam int KIND_FLAG   = 2;

	logic      clk;
	logic      rst;
	logic      psel;
	logic      penable;
	logic      pwrite;
	reg_addr_t paddr;
	word_t     pwdata;
	word_t     prdata;
	logic      pready;
	logic      pslverr;
	// TX looped straight back into RX
	logic      serial_line;

	int          errors;
	int unsigned n_written;
	int unsigned n_read;
	int unsigned n_dropped;
	logic        dropped;
	// Words still expected back, oldest first
	word_t       sent_q[$];
	// Results waiting for the compare process
	int          kind_q[$];
	word_t       got_q[$];
	word_t       exp_q[$];
	string       what_q[$];

	always #10 clk = ~clk;

	spart_top spart_top_inst (
		.clk       (clk),
		.rst       (rst),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr),
		.i_rxd     (serial_line),
		.o_txd     (serial_line)
	);

	////////////////////
	// Reference and compare
	////////////////////

	// STATUS once the line is quiet, busy never set here
	function automatic word_t expected_status(int unsigned written, int unsigned read,
		logic drop);
		word_t st;
		st = '0;
		st[STATUS_RX_READY] = (written > read);
		st[STATUS_OVERRUN]  = drop;
		return st;
	endfunction

	task automatic check_word(word_t got, word_t exp, string what);
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Only the three flag bits count
	task automatic check_status(word_t got, word_t exp, string what);
		if ((got & STATUS_MASK) !== (exp & STATUS_MASK))
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what,
				got[2:0], exp[2:0]);
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic post_result(int kind, word_t got, word_t exp, string what);
		kind_q.push_back(kind);
		got_q.push_back(got);
		exp_q.push_back(exp);
		what_q.push_back(what);
	endtask

	// Compare process, drains the queue mid cycle
	always @(negedge clk)
	begin
		while (kind_q.size() != 0)
		begin
			case (kind_q[0])
				KIND_WORD:   check_word(got_q[0], exp_q[0], what_q[0]);
				KIND_STATUS: check_status(got_q[0], exp_q[0], what_q[0]);
				default:     check_flag(got_q[0][0], exp_q[0][0], what_q[0]);
			endcase
			kind_q.delete(0);
			got_q.delete(0);
			exp_q.delete(0);
			what_q.delete(0);
		end
	end

	////////////////////
	// APB tasks
	////////////////////

	// Setup cycle, then access until PREADY; response sampled at negedge
	task automatic apb_transfer(logic write, reg_addr_t addr, word_t wdata,
		output word_t rdata, output logic err, output int stalls);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		stalls = 0;
		@(negedge clk);
		while (!pready)
		begin
			stalls++;
			@(negedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		// Transfer completes on this edge
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(reg_addr_t addr, word_t data, output logic err,
		output int stalls);
		word_t unused;
		apb_transfer(1'b1, addr, data, unused, err, stalls);
	endtask

	task automatic apb_read(reg_addr_t addr, output word_t data, output logic err);
		int stalls;
		apb_transfer(1'b0, addr, '0, data, err, stalls);
	endtask

	////////////////////
	// Test steps
	////////////////////

	task automatic send_word(word_t w, output int stalls);
		logic err;
		apb_write(ADDR_DATA, w, err, stalls);
		post_result(KIND_FLAG, word_t'(err), '0, "DATA write error");
		sent_q.push_back(w);
		n_written++;
	endtask

	// Poll STATUS until one flag shows up
	task automatic wait_status(int bit_pos);
		word_t st;
		logic  err;
		st = '0;
		while (!st[bit_pos])
			apb_read(ADDR_STATUS, st, err);
	endtask

	// Oldest word still owed is the one that comes back
	task automatic take_word();
		word_t got;
		word_t exp;
		logic  err;
		apb_read(ADDR_DATA, got, err);
		exp = sent_q.pop_front();
		n_read++;
		dropped = 1'b0;
		post_result(KIND_WORD, got, exp, "DATA read");
		post_result(KIND_FLAG, word_t'(err), '0, "DATA read error");
	endtask

	task automatic status_now(string what);
		word_t st;
		logic  err;
		apb_read(ADDR_STATUS, st, err);
		post_result(KIND_STATUS, st, expected_status(n_written - n_dropped, n_read, dropped),
			what);
	endtask

	task automatic set_divisor(divisor_t div);
		word_t got;
		logic  err;
		int    stalls;
		apb_write(ADDR_DIVISOR, word_t'(div), err, stalls);
		apb_read(ADDR_DIVISOR, got, err);
		post_result(KIND_WORD, got, word_t'(div), "DIVISOR read back");
	endtask

	// One word out and back through the loopback
	task automatic round_trip(word_t w);
		int stalls;
		send_word(w, stalls);
		wait_status(STATUS_RX_READY);
		status_now("STATUS with word ready");
		take_word();
		status_now("STATUS after read");
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		word_t    got;
		word_t    exp;
		logic     err;
		int       stalls;
		divisor_t div_a;
		divisor_t div_b;
		clk = 1'b0;
		void'($urandom(15580));
		errors    = 0;
		n_written = 0;
		n_read    = 0;
		n_dropped = 0;
		dropped   = 1'b0;
		rst     <= 1'b1;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		// Register values out of reset
		status_now("STATUS after reset");
		apb_read(ADDR_DIVISOR, got, err);
		post_result(KIND_WORD, got, word_t'(DIVISOR_RESET), "DIVISOR after reset");
		apb_read(ADDR_DATA, got, err);
		post_result(KIND_WORD, got, '0, "empty DATA read");
		post_result(KIND_FLAG, word_t'(err), word_t'(1), "empty DATA read error");
		apb_read(4'd12, got, err);
		post_result(KIND_FLAG, word_t'(err), word_t'(1), "unmapped read error");

		// Single word at a fast bit rate
		div_a = divisor_t'(4 + $urandom % 13);
		set_divisor(div_a);
		round_trip($urandom);

		// Back to back, the second write has to wait
		send_word($urandom, stalls);
		apb_read(ADDR_STATUS, got, err);
		exp = expected_status(n_read, n_read, 1'b0);
		exp[STATUS_TX_BUSY] = 1'b1;
		post_result(KIND_STATUS, got, exp, "STATUS while sending");
		send_word($urandom, stalls);
		post_result(KIND_FLAG, word_t'(stalls > 0), word_t'(1), "second DATA write stall");
		wait_status(STATUS_RX_READY);
		take_word();
		wait_status(STATUS_RX_READY);
		take_word();
		status_now("STATUS after two words");

		// Second word lands on a full slot and is lost
		send_word($urandom, stalls);
		send_word($urandom, stalls);
		void'(sent_q.pop_back());
		n_dropped++;
		dropped = 1'b1;
		wait_status(STATUS_OVERRUN);
		status_now("STATUS after overrun");
		take_word();
		status_now("STATUS after overrun read");

		// Burst at another bit rate
		div_b = divisor_t'(4 + (div_a - 4 + 1 + $urandom % 12) % 13);
		set_divisor(div_b);
		repeat (20) round_trip($urandom);

		while (kind_q.size() != 0)
			@(posedge clk);
		@(posedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
verilog/spart_pkg.sv
verilog/spart_ifs.sv
verilog/spart_apb_slave.sv
verilog/spart_word_engine.sv
verilog/spart_uart.sv
verilog/spart_top.sv
test/spart_props.sv
test/tb_spart.sv

//--- run.sh
#!/bin/sh
# Build and run the SPART loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_spart \
	-f filelist.f -o sim_tb_spart
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_spart > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0
